/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fp_adder
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Output is echoed, then searched for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* design/fp_adder_top.sv */
`timescale 1ns/1ns

module fp_adder_top #(
  parameter int P = fp_format_pkg::man_w,
  parameter int E = fp_format_pkg::exp_w
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [P+E:0]                     op_a,
  input  logic [P+E:0]                     op_b,
  input  fp_status_pkg::fp_op_e            op,
  input  logic                             start,
  input  logic                             ready_in,
  output logic                             valid_out,
  output logic                             ready_out,
  output logic                             sign_out,
  output logic [E-1:0]                     exp_out,
  output logic [P+3:0]                     mant_out,
  output logic [fp_status_pkg::flag_w-1:0] flags
);

  logic load;
  logic shift;
  logic done;

  align_if #(.P(P), .E(E)) align_bus ();
  sum_if   #(.P(P), .E(E)) sum_bus ();

  fp_align #(.P(P), .E(E)) u_align (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_a      (op_a),
    .op_b      (op_b),
    .op        (op),
    .start     (start),
    .ready_out (ready_out),
    .align     (align_bus)
  );

  fp_addsub #(.P(P), .E(E)) u_addsub (
    .clk   (clk),
    .rst_n (rst_n),
    .align (align_bus),
    .sum   (sum_bus)
  );

  // Normalizer is a controller steering a shifting datapath
  fp_norm_ctrl u_norm_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .sum       (sum_bus),
    .ready_in  (ready_in),
    .valid_out (valid_out),
    .load      (load),
    .shift     (shift),
    .done      (done)
  );

  fp_norm_shift #(.P(P), .E(E)) u_norm_shift (
    .clk      (clk),
    .rst_n    (rst_n),
    .sum      (sum_bus),
    .load     (load),
    .shift    (shift),
    .done     (done),
    .mant_out (mant_out),
    .exp_out  (exp_out),
    .sign_out (sign_out),
    .flags    (flags)
  );

endmodule

/* design/fp_addsub.sv */
`timescale 1ns/1ns

module fp_addsub #(
  parameter int P = fp_format_pkg::man_w,
  parameter int E = fp_format_pkg::exp_w
) (
  input  logic clk,
  input  logic rst_n,
  align_if.dst align,
  sum_if.src   sum
);

  localparam int           mant_w  = P + 4;
  localparam logic [E-1:0] exp_max = '1;

  logic [mant_w-1:0]                sum_nxt;
  logic                             carry_nxt;
  logic                             sign_nxt;
  logic [E-1:0]                     exp_nxt;
  logic [fp_status_pkg::flag_w-1:0] flags_nxt;
  logic                             invalid;

  // NaN in, or inf minus inf
  assign invalid = align.nan_a || align.nan_b ||
                   (align.inf_a && align.inf_b && (align.sign_a != align.sign_b));

  assign align.ready = sum.ready;

  always_comb begin
    sum_nxt   = '0;
    carry_nxt = 1'b0;
    sign_nxt  = 1'b0;
    exp_nxt   = exp_max;
    flags_nxt = '0;
    if (invalid) begin
      sum_nxt = {2'b11, {(mant_w - 2){1'b0}}};
      flags_nxt[fp_status_pkg::flag_invalid] = 1'b1;
    end else if (align.inf_a) begin
      sum_nxt  = {1'b1, {(mant_w - 1){1'b0}}};
      sign_nxt = align.sign_a;
    end else if (align.inf_b) begin
      sum_nxt  = {1'b1, {(mant_w - 1){1'b0}}};
      sign_nxt = align.sign_b;
    end else begin
      exp_nxt = align.exp;
      if (align.sign_a == align.sign_b) begin
        {carry_nxt, sum_nxt} = {1'b0, align.mant_a} + {1'b0, align.mant_b};
        sign_nxt = align.sign_a;
      end else if (align.mant_a >= align.mant_b) begin
        // Ties go to a, so x - x keeps the sign of a
        sum_nxt  = align.mant_a - align.mant_b;
        sign_nxt = align.sign_a;
      end else begin
        sum_nxt  = align.mant_b - align.mant_a;
        sign_nxt = align.sign_b;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum.valid <= 1'b0;
      sum.sum   <= '0;
      sum.carry <= 1'b0;
      sum.sign  <= 1'b0;
      sum.exp   <= '0;
      sum.flags <= '0;
    end else begin
      if (sum.ready) begin
        sum.valid <= align.valid;
      end
      if (align.valid && sum.ready) begin
        sum.sum   <= sum_nxt;
        sum.carry <= carry_nxt;
        sum.sign  <= sign_nxt;
        sum.exp   <= exp_nxt;
        sum.flags <= flags_nxt;
      end
    end
  end

endmodule

/* design/fp_align.sv */
`timescale 1ns/1ns

module fp_align #(
  parameter int P = fp_format_pkg::man_w,
  parameter int E = fp_format_pkg::exp_w
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [P+E:0]          op_a,
  input  logic [P+E:0]          op_b,
  input  fp_status_pkg::fp_op_e op,
  input  logic                  start,
  output logic                  ready_out,
  align_if.src                  align
);

  localparam int           mant_w  = P + 4;
  localparam logic [E-1:0] exp_max = '1;

  logic              sign_a;
  logic              sign_b;
  logic [E-1:0]      exp_a;
  logic [E-1:0]      exp_b;
  logic [E-1:0]      exp_diff;
  logic [mant_w-1:0] full_a;
  logic [mant_w-1:0] full_b;

  assign sign_a = op_a[P+E];
  // Subtraction is addition with b negated
  assign sign_b = op_b[P+E] ^ (op == fp_status_pkg::op_sub);
  assign exp_a  = op_a[P+E-1:P];
  assign exp_b  = op_b[P+E-1:P];

  // Hidden bit, fraction, then zero guard bits
  assign full_a = {exp_a != '0, op_a[P-1:0], {fp_format_pkg::guard_w{1'b0}}};
  assign full_b = {exp_b != '0, op_b[P-1:0], {fp_format_pkg::guard_w{1'b0}}};

  assign exp_diff = (exp_a >= exp_b) ? exp_a - exp_b : exp_b - exp_a;

  assign ready_out = align.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      align.valid  <= 1'b0;
      align.mant_a <= '0;
      align.mant_b <= '0;
      align.exp    <= '0;
      align.sign_a <= 1'b0;
      align.sign_b <= 1'b0;
      align.nan_a  <= 1'b0;
      align.nan_b  <= 1'b0;
      align.inf_a  <= 1'b0;
      align.inf_b  <= 1'b0;
    end else begin
      if (align.ready) begin
        align.valid <= start;
      end
      if (start && align.ready) begin
        align.sign_a <= sign_a;
        align.sign_b <= sign_b;
        align.nan_a  <= (exp_a == exp_max) && (op_a[P-1:0] != '0);
        align.nan_b  <= (exp_b == exp_max) && (op_b[P-1:0] != '0);
        align.inf_a  <= (exp_a == exp_max) && (op_a[P-1:0] == '0);
        align.inf_b  <= (exp_b == exp_max) && (op_b[P-1:0] == '0);
        // Smaller operand shifts right, bits falling off the end are lost
        if (exp_a >= exp_b) begin
          align.exp    <= exp_a;
          align.mant_a <= full_a;
          align.mant_b <= (exp_diff >= mant_w) ? '0 : full_b >> exp_diff;
        end else begin
          align.exp    <= exp_b;
          align.mant_a <= (exp_diff >= mant_w) ? '0 : full_a >> exp_diff;
          align.mant_b <= full_b;
        end
      end
    end
  end

endmodule

/* design/fp_align_if.sv */
`timescale 1ns/1ns

interface align_if #(
  parameter int P = fp_format_pkg::man_w,
  parameter int E = fp_format_pkg::exp_w
);

  logic         valid;
  logic         ready;
  logic [P+3:0] mant_a;
  logic [P+3:0] mant_b;
  logic [E-1:0] exp;
  logic         sign_a;
  logic         sign_b;
  logic         nan_a;
  logic         nan_b;
  logic         inf_a;
  logic         inf_b;

  modport src (
    output valid, mant_a, mant_b, exp, sign_a, sign_b, nan_a, nan_b, inf_a, inf_b,
    input  ready
  );

  modport dst (
    input  valid, mant_a, mant_b, exp, sign_a, sign_b, nan_a, nan_b, inf_a, inf_b,
    output ready
  );

endinterface

/* design/fp_format_pkg.sv */
package fp_format_pkg;

  // Single precision by default
  parameter int man_w = 23;
  parameter int exp_w = 8;

  // Extra bits carried below the mantissa LSB through add and normalize
  parameter int guard_w = 3;

endpackage

/* design/fp_norm_ctrl.sv */
`timescale 1ns/1ns

module fp_norm_ctrl (
  input  logic clk,
  input  logic rst_n,
  sum_if.ctrl  sum,
  input  logic ready_in,
  output logic valid_out,
  output logic load,
  output logic shift,
  input  logic done
);

  fp_status_pkg::norm_state_e state;
  fp_status_pkg::norm_state_e state_nxt;

  // Busy while shifting, and stalled by the consumer otherwise
  assign sum.ready = (state != fp_status_pkg::norm_shift) && ready_in;
  assign load      = sum.valid && sum.ready;
  assign shift     = (state == fp_status_pkg::norm_shift) && !done;
  assign valid_out = (state == fp_status_pkg::norm_hold);

  always_comb begin
    state_nxt = state;
    case (state)
      fp_status_pkg::norm_idle: begin
        if (load) begin
          state_nxt = fp_status_pkg::norm_shift;
        end
      end
      fp_status_pkg::norm_shift: begin
        if (done) begin
          state_nxt = fp_status_pkg::norm_hold;
        end
      end
      fp_status_pkg::norm_hold: begin
        // Back to back when the next item is waiting
        if (load) begin
          state_nxt = fp_status_pkg::norm_shift;
        end else if (ready_in) begin
          state_nxt = fp_status_pkg::norm_idle;
        end
      end
      default: state_nxt = fp_status_pkg::norm_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= fp_status_pkg::norm_idle;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

/* design/fp_norm_shift.sv */
`timescale 1ns/1ns

module fp_norm_shift #(
  parameter int P = fp_format_pkg::man_w,
  parameter int E = fp_format_pkg::exp_w
) (
  input  logic                             clk,
  input  logic                             rst_n,
  sum_if.data                              sum,
  input  logic                             load,
  input  logic                             shift,
  output logic                             done,
  output logic [P+3:0]                     mant_out,
  output logic [E-1:0]                     exp_out,
  output logic                             sign_out,
  output logic [fp_status_pkg::flag_w-1:0] flags
);

  localparam logic [E-1:0] exp_max = '1;

  logic [P+3:0]                     load_mant;
  logic [E-1:0]                     load_exp;
  logic [fp_status_pkg::flag_w-1:0] load_flags;
  logic [E-1:0]                     exp_inc;
  logic [E-1:0]                     exp_dec;

  assign exp_inc = sum.exp + 1'b1;
  assign exp_dec = exp_out - 1'b1;

  // Normalized, zero, or pinned at an exponent limit
  assign done = (mant_out == '0) || mant_out[P+3] ||
                (exp_out == '0) || (exp_out == exp_max);

  always_comb begin
    load_mant  = sum.sum;
    load_exp   = sum.exp;
    load_flags = sum.flags;
    if (sum.carry && (sum.exp != exp_max)) begin
      // Carry becomes the new top bit
      load_mant = {1'b1, sum.sum[P+3:1]};
      load_exp  = exp_inc;
      if (sum.sum[0]) begin
        load_flags[fp_status_pkg::flag_inexact] = 1'b1;
      end
      if (exp_inc == exp_max) begin
        load_mant = '0;
        load_flags[fp_status_pkg::flag_overflow] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mant_out <= '0;
      exp_out  <= '0;
      sign_out <= 1'b0;
      flags    <= '0;
    end else if (load) begin
      mant_out <= load_mant;
      exp_out  <= load_exp;
      sign_out <= sum.sign;
      flags    <= load_flags;
    end else if (shift) begin
      mant_out <= mant_out << 1;
      exp_out  <= exp_dec;
      if (exp_dec == '0) begin
        flags[fp_status_pkg::flag_underflow] <= 1'b1;
        flags[fp_status_pkg::flag_inexact]   <= 1'b1;
      end
    end
  end

endmodule

/* design/fp_status_pkg.sv */
package fp_status_pkg;

  parameter int flag_w = 4;

  // Bit positions inside the flag vector
  typedef enum int unsigned {
    flag_invalid   = 0,
    flag_overflow  = 1,
    flag_underflow = 2,
    flag_inexact   = 3
  } flag_idx_e;

  typedef enum logic {
    op_add = 1'b0,
    op_sub = 1'b1
  } fp_op_e;

  typedef enum logic [1:0] {
    norm_idle,
    norm_shift,
    norm_hold
  } norm_state_e;

endpackage

/* design/fp_sum_if.sv */
`timescale 1ns/1ns

interface sum_if #(
  parameter int P = fp_format_pkg::man_w,
  parameter int E = fp_format_pkg::exp_w
);

  logic                             valid;
  logic                             ready;
  logic [P+3:0]                     sum;
  logic                             carry;
  logic                             sign;
  logic [E-1:0]                     exp;
  logic [fp_status_pkg::flag_w-1:0] flags;

  modport src (
    output valid, sum, carry, sign, exp, flags,
    input  ready
  );

  // Handshake side of the normalizer
  modport ctrl (
    input  valid,
    output ready
  );

  // Payload side of the normalizer
  modport data (
    input sum, carry, sign, exp, flags
  );

endinterface

/* list.f */
+incdir+include
design/fp_format_pkg.sv
design/fp_status_pkg.sv
design/fp_align_if.sv
design/fp_sum_if.sv
design/fp_align.sv
design/fp_addsub.sv
design/fp_norm_ctrl.sv
design/fp_norm_shift.sv
design/fp_adder_top.sv
verif/tb_fp_adder.sv

/* include/fp_ref_model.svh */
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

localparam int ref_m = fp_format_pkg::man_w;
localparam int ref_x = fp_format_pkg::exp_w;
localparam int ref_w = fp_format_pkg::man_w + fp_format_pkg::guard_w + 1;

typedef struct packed {
  logic                             sign;
  logic [ref_x-1:0]                 exp;
  logic [ref_w-1:0]                 mant;
  logic [fp_status_pkg::flag_w-1:0] flags;
} fp_ref_t;

// Unrounded result as the pipeline produces it
function automatic fp_ref_t fp_ref_model(input logic [ref_m+ref_x:0] a,
                                         input logic [ref_m+ref_x:0] b,
                                         input fp_status_pkg::fp_op_e op);
  logic                             sa;
  logic                             sb;
  logic                             sign;
  logic                             carry;
  logic [ref_x-1:0]                 ea;
  logic [ref_x-1:0]                 eb;
  logic [ref_x-1:0]                 exp;
  logic [ref_x-1:0]                 ediff;
  logic [ref_w-1:0]                 ma;
  logic [ref_w-1:0]                 mb;
  logic [ref_w-1:0]                 mant;
  logic [fp_status_pkg::flag_w-1:0] flags;
  fp_ref_t                          res;

  sa = a[ref_m+ref_x];
  sb = b[ref_m+ref_x] ^ (op == fp_status_pkg::op_sub);
  ea = a[ref_m+ref_x-1:ref_m];
  eb = b[ref_m+ref_x-1:ref_m];
  ma = {ea != '0, a[ref_m-1:0], {fp_format_pkg::guard_w{1'b0}}};
  mb = {eb != '0, b[ref_m-1:0], {fp_format_pkg::guard_w{1'b0}}};
  if (ea >= eb) begin
    exp   = ea;
    ediff = ea - eb;
    mb    = (ediff >= ref_w) ? '0 : mb >> ediff;
  end else begin
    exp   = eb;
    ediff = eb - ea;
    ma    = (ediff >= ref_w) ? '0 : ma >> ediff;
  end
  flags = '0;
  carry = 1'b0;
  if ((&ea && |a[ref_m-1:0]) || (&eb && |b[ref_m-1:0]) ||
      (&ea && &eb && ~|a[ref_m-1:0] && ~|b[ref_m-1:0] && sa != sb)) begin
    exp  = '1;
    mant = {2'b11, {(ref_w - 2){1'b0}}};
    sign = 1'b0;
    flags[fp_status_pkg::flag_invalid] = 1'b1;
  end else if (&ea) begin
    exp  = '1;
    mant = {1'b1, {(ref_w - 1){1'b0}}};
    sign = sa;
  end else if (&eb) begin
    exp  = '1;
    mant = {1'b1, {(ref_w - 1){1'b0}}};
    sign = sb;
  end else if (sa == sb) begin
    {carry, mant} = {1'b0, ma} + {1'b0, mb};
    sign = sa;
  end else if (ma >= mb) begin
    mant = ma - mb;
    sign = sa;
  end else begin
    mant = mb - ma;
    sign = sb;
  end
  if (carry && exp != '1) begin
    if (mant[0]) begin
      flags[fp_status_pkg::flag_inexact] = 1'b1;
    end
    mant = {1'b1, mant[ref_w-1:1]};
    exp  = exp + 1'b1;
    if (&exp) begin
      mant = '0;
      flags[fp_status_pkg::flag_overflow] = 1'b1;
    end
  end
  while (mant != '0 && !mant[ref_w-1] && exp != '0 && exp != '1) begin
    mant = mant << 1;
    exp  = exp - 1'b1;
    if (exp == '0) begin
      flags[fp_status_pkg::flag_underflow] = 1'b1;
      flags[fp_status_pkg::flag_inexact]   = 1'b1;
    end
  end
  res.sign  = sign;
  res.exp   = exp;
  res.mant  = mant;
  res.flags = flags;
  return res;
endfunction

`endif

/* verif/tb_fp_adder.sv */
`timescale 1ns/1ns

module tb_fp_adder;

  localparam int P        = fp_format_pkg::man_w;
  localparam int E        = fp_format_pkg::exp_w;
  localparam int W        = P + E + 1;
  localparam int FW       = fp_status_pkg::flag_w;
  localparam int exp_span = (1 << E) - 2;
  localparam int n_random = 20;

  `include "fp_ref_model.svh"

  typedef struct {
    logic [W-1:0]          a;
    logic [W-1:0]          b;
    fp_status_pkg::fp_op_e op;
    logic [7:0]            rdy;
    logic                  chk;
    logic [FW-1:0]         flg;
  } stim_t;

  typedef struct {
    int            idx;
    fp_ref_t       res;
    logic          chk;
    logic [FW-1:0] flg;
  } pend_t;

  logic                  clk;
  logic                  rst_n;
  logic [W-1:0]          op_a;
  logic [W-1:0]          op_b;
  fp_status_pkg::fp_op_e op;
  logic                  start;
  logic                  ready_in;
  logic                  valid_out;
  logic                  ready_out;
  logic                  sign_out;
  logic [E-1:0]          exp_out;
  logic [P+3:0]          mant_out;
  logic [FW-1:0]         flags;

  stim_t      tbl[$];
  pend_t      pending[$];
  logic [2:0] phase;
  int         cycle_limit = 0;
  int         cycles = 0;
  int         received = 0;
  int         passed = 0;
  int         failed = 0;
  int         errors = 0;

  fp_adder_top #(.P(P), .E(E)) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_a      (op_a),
    .op_b      (op_b),
    .op        (op),
    .start     (start),
    .ready_in  (ready_in),
    .valid_out (valid_out),
    .ready_out (ready_out),
    .sign_out  (sign_out),
    .exp_out   (exp_out),
    .mant_out  (mant_out),
    .flags     (flags)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic add_row(input logic [W-1:0] a, input logic [W-1:0] b,
                         input fp_status_pkg::fp_op_e o, input logic [7:0] rdy,
                         input logic chk, input logic [FW-1:0] flg);
    stim_t s;
    s.a   = a;
    s.b   = b;
    s.op  = o;
    s.rdy = rdy;
    s.chk = chk;
    s.flg = flg;
    tbl.push_back(s);
  endtask

  task automatic build_table();
    logic [31:0]           rng;
    logic [E-1:0]          ea;
    int                    eb_i;
    logic [W-1:0]          a;
    logic [W-1:0]          b;
    fp_status_pkg::fp_op_e o;
    logic [7:0]            rdy;
    // Operand a, operand b, opcode, ready_in pattern, check flags, flags {inx,unf,ovf,inv}
    add_row(32'h3FC0_0000, 32'h3FC0_0000, fp_status_pkg::op_add, 8'hFF, 1'b1, 4'b0000);
    add_row(32'h3FFF_FFFF, 32'h3E00_0001, fp_status_pkg::op_add, 8'h0F, 1'b1, 4'b1000);
    add_row(32'h3FC0_0000, 32'h3FA0_0000, fp_status_pkg::op_sub, 8'hC3, 1'b1, 4'b0000);
    add_row(32'h4000_0000, 32'hBFF0_0000, fp_status_pkg::op_add, 8'h55, 1'b1, 4'b0000);
    add_row(32'h3F80_0001, 32'h3F80_0000, fp_status_pkg::op_sub, 8'h81, 1'b1, 4'b0000);
    add_row(32'h4049_0FDB, 32'h4049_0FDB, fp_status_pkg::op_sub, 8'hFF, 1'b1, 4'b0000);
    add_row(32'hC049_0FDB, 32'hC049_0FDB, fp_status_pkg::op_sub, 8'h33, 1'b1, 4'b0000);
    add_row(32'h7FC0_0000, 32'h3F80_0000, fp_status_pkg::op_add, 8'hFF, 1'b1, 4'b0001);
    add_row(32'h3F80_0000, 32'h7FA0_0000, fp_status_pkg::op_sub, 8'h81, 1'b1, 4'b0001);
    add_row(32'h7F80_0000, 32'hFF80_0000, fp_status_pkg::op_add, 8'hF0, 1'b1, 4'b0001);
    add_row(32'h7F80_0000, 32'h7F80_0000, fp_status_pkg::op_sub, 8'hFF, 1'b1, 4'b0001);
    add_row(32'hFF80_0000, 32'h3F80_0000, fp_status_pkg::op_add, 8'h5A, 1'b1, 4'b0000);
    add_row(32'h3F80_0000, 32'h7F80_0000, fp_status_pkg::op_sub, 8'hFF, 1'b1, 4'b0000);
    add_row(32'h7F80_0000, 32'h7F80_0000, fp_status_pkg::op_add, 8'h0F, 1'b1, 4'b0000);
    add_row(32'h7F7F_FFFF, 32'h7F7F_FFFF, fp_status_pkg::op_add, 8'hFF, 1'b1, 4'b0010);
    add_row(32'hFF00_0000, 32'hFF00_0000, fp_status_pkg::op_add, 8'hC3, 1'b1, 4'b0010);
    add_row(32'h00C0_0000, 32'h00A0_0000, fp_status_pkg::op_sub, 8'hFF, 1'b1, 4'b1100);
    add_row(32'h3F80_0000, 32'h0000_0000, fp_status_pkg::op_add, 8'h81, 1'b1, 4'b0000);
    rng = 32'h4831_01ce;
    for (int k = 0; k < n_random; k++) begin
      rng = lcg_next(rng);
      ea  = E'(1 + rng % exp_span);
      rng = lcg_next(rng);
      // Half the pairs get close exponents so that cancellation shows up
      if (rng[31]) begin
        eb_i = int'(ea) + int'(rng[26:24]) - 3;
      end else begin
        eb_i = 1 + int'(rng % exp_span);
      end
      if (eb_i < 1) begin
        eb_i = 1;
      end
      if (eb_i > exp_span) begin
        eb_i = exp_span;
      end
      rng = lcg_next(rng);
      a   = {rng[31], ea, rng[P+7:8]};
      rng = lcg_next(rng);
      b   = {rng[31], E'(eb_i), rng[P+7:8]};
      rng = lcg_next(rng);
      o   = fp_status_pkg::fp_op_e'(rng[29]);
      rdy = rng[23:16] | 8'h11;
      add_row(a, b, o, rdy, 1'b0, '0);
    end
  endtask

  initial begin : main_seq
    logic  accepted;
    pend_t item;
    rst_n    = 1'b0;
    op_a     = '0;
    op_b     = '0;
    op       = fp_status_pkg::op_add;
    start    = 1'b0;
    ready_in = 1'b0;
    phase    = '0;
    build_table();
    cycle_limit = tbl.size() * (P + 10) + 50;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int i = 0; i < tbl.size(); i++) begin
      op_a     = tbl[i].a;
      op_b     = tbl[i].b;
      op       = tbl[i].op;
      start    = 1'b1;
      accepted = 1'b0;
      while (!accepted) begin
        ready_in = tbl[i].rdy[phase];
        phase    = phase + 1'b1;
        @(negedge clk);
        if (ready_out) begin
          accepted  = 1'b1;
          item.idx  = i;
          item.res  = fp_ref_model(tbl[i].a, tbl[i].b, tbl[i].op);
          item.chk  = tbl[i].chk;
          item.flg  = tbl[i].flg;
          pending.push_back(item);
        end
        @(posedge clk);
        #1;
      end
    end
    start = 1'b0;
    while (received < tbl.size()) begin
      ready_in = phase[0] | phase[2];
      phase    = phase + 1'b1;
      @(posedge clk);
      #1;
    end
    // Extra cycles catch a duplicated result
    ready_in = 1'b1;
    repeat (10) @(posedge clk);
    $display("Tests %0d, received %0d, passed %0d, failed %0d, other errors %0d",
             tbl.size(), received, passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  always @(negedge clk) begin : result_check
    pend_t want;
    int    bad;
    // A stalled consumer blocks the input, and a taken result frees it
    if (rst_n && (!ready_in || valid_out)) begin
      if (ready_out !== ready_in) begin
        $display("Mismatch at %0t: ready_out expected %b got %b",
                 $time, ready_in, ready_out);
        errors++;
      end
    end
    if (rst_n && valid_out && ready_in) begin
      if (pending.size() == 0) begin
        $display("Error at %0t: result delivered with no input pending", $time);
        errors++;
      end else begin
        want = pending.pop_front();
        bad  = 0;
        if (sign_out !== want.res.sign) begin
          $display("Mismatch at %0t: sign_out expected %b got %b",
                   $time, want.res.sign, sign_out);
          bad++;
        end
        if (exp_out !== want.res.exp) begin
          $display("Mismatch at %0t: exp_out expected %h got %h",
                   $time, want.res.exp, exp_out);
          bad++;
        end
        if (mant_out !== want.res.mant) begin
          $display("Mismatch at %0t: mant_out expected %h got %h",
                   $time, want.res.mant, mant_out);
          bad++;
        end
        if (flags !== want.res.flags) begin
          $display("Mismatch at %0t: flags expected %b got %b",
                   $time, want.res.flags, flags);
          bad++;
        end
        // Directed rows also carry hand-worked flags
        if (want.chk && flags !== want.flg) begin
          $display("Mismatch at %0t: flags (table) expected %b got %b",
                   $time, want.flg, flags);
          bad++;
        end
        if (bad == 0) begin
          passed++;
          $display("Test %0d: ok", want.idx);
        end else begin
          failed++;
          $display("Test %0d: %0d wrong fields", want.idx, bad);
        end
        received++;
      end
    end
  end

  initial begin : watchdog
    wait (cycle_limit > 0);
    while (cycles <= cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d of %0d results received",
             cycles, received, tbl.size());
    $display("Simulation FAILED");
    $finish;
  end

endmodule
